// File: flist.f
src/evrPkg.sv
src/evrCommaAlign.sv
src/evrEventDecode.sv
src/evrMarkerStretch.sv
src/evrEventMonitor.sv
src/evrApbRegs.sv
src/evrTop.sv
test/evrClkGen.sv
test/evrTb.sv

// File: Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = evrTb
FLIST  = flist.f
BUILD  = obj_dir
BIN    = $(BUILD)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/evrTb.sv
// directed testbench for the event receiver fabric top
`timescale 1ns/1ps

module evrTb;

    localparam int clkPeriod        = 100;
    localparam int outputCount      = 8;
    localparam int commasNeeded     = 8;
    localparam int hbStretchCycles  = 20;
    localparam int ppsStretchCycles = 6;
    localparam int monitorDepth     = 4;
    localparam int watchdogCycles   = 5000;  // all tests take a few hundred cycles

    logic                   evrClk;
    logic                   rstN;
    evrPkg::rxWord_t        rxWord;
    evrPkg::apbReq_t        apbReq;
    evrPkg::apbRsp_t        apbRsp;
    logic                   aligned;
    logic                   bitSlide;
    evrPkg::evrCode_t       code;
    logic                   codeValid;
    logic [outputCount-1:0] trigger;
    logic                   hbMarker;
    logic                   ppsMarker;
    logic [15:0]            expAction [256];  // model of the action table
    int                     errorCount;

    evrClkGen #(.periodNs(clkPeriod), .resetCycles(16)) clkGen (
        .evrClk (evrClk),
        .rstN_o (rstN)
    );

    evrTop #(
        .outputCount      (outputCount),
        .commasNeeded     (commasNeeded),
        .hbStretchCycles  (hbStretchCycles),
        .ppsStretchCycles (ppsStretchCycles),
        .monitorDepth     (monitorDepth)
    ) u_dut (
        .evrClk         (evrClk),
        .rstN_i         (rstN),
        .rxWord_i       (rxWord),
        .apb_i          (apbReq),
        .apb_o          (apbRsp),
        .aligned_o      (aligned),
        .bitSlide_o     (bitSlide),
        .evrCode_o      (code),
        .evrCodeValid_o (codeValid),
        .evrTrigger_o   (trigger),
        .evrHbMarker_o  (hbMarker),
        .evrPpsMarker_o (ppsMarker)
    );

    ////////////////////////////////////////////////////////////////////////////
    // low level helpers
    task automatic nextCycle();
        @(posedge evrClk);
        #5;  // registered outputs settled, new stimulus goes here
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            errorCount++;
            $display("error %s: %s expected 0x%0h actual 0x%0h",
                     testName, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic driveWord(input evrPkg::evrCode_t c, input logic [1:0] k,
                             input logic [1:0] nit);
        rxWord = '{data: {8'h00, c}, isK: k, notInTable: nit};
    endtask

    task automatic sendCommas(input int n);
        repeat (n) begin
            driveWord(evrPkg::kComma, 2'b01, 2'b00);
            nextCycle();
        end
    endtask

    task automatic alignLink(input string testName);
        sendCommas(commasNeeded);
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();  // aligned_o lags the internal flag by one
        checkValue(testName, "aligned after commas", 1, aligned);
    endtask

    function automatic evrPkg::evrCode_t randomCode();
        evrPkg::evrCode_t c;
        c = evrPkg::evrCode_t'(1 + $urandom % 250);
        if (c == evrPkg::heartbeatCode) begin
            c = c + 8'd1;  // keep the heartbeat quiet
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB, setup cycle then access cycle
    task automatic apbAccess(input logic write, input evrPkg::apbAddr_t addr,
                             input evrPkg::apbData_t wdata,
                             output evrPkg::apbData_t rdata, output logic err);
        apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        nextCycle();
        apbReq.penable = 1'b1;
        #40;  // mid cycle, response is combinational
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        assert (apbRsp.pready) else begin
            errorCount++;
            $display("APB slave did not signal ready in the access cycle");
            $display("Simulation finished: FAIL");
            $fatal(1, "APB ready missing");
        end
        nextCycle();
        apbReq = '0;
    endtask

    task automatic apbWrite(input evrPkg::apbAddr_t addr, input evrPkg::apbData_t data,
                            input string testName);
        evrPkg::apbData_t rdata;
        logic             err;
        apbAccess(1'b1, addr, data, rdata, err);
        checkValue(testName, "pslverr on write", 0, err);
    endtask

    task automatic apbRead(input evrPkg::apbAddr_t addr, input string testName,
                           output evrPkg::apbData_t data);
        logic err;
        apbAccess(1'b0, addr, '0, data, err);
        checkValue(testName, "pslverr on read", 0, err);
    endtask

    task automatic setAction(input evrPkg::evrCode_t c, input logic [15:0] bits,
                             input string testName);
        apbWrite(evrPkg::regActionBase + evrPkg::apbAddr_t'({c, 2'b00}), {16'h0, bits},
                 testName);
        expAction[c] = bits;
    endtask

    // counts samples with the marker high, stops on its fall
    task automatic countHigh(input bit pps, output int width);
        width = 0;
        while ((pps ? ppsMarker : hbMarker) && width < 4 * hbStretchCycles) begin
            width++;
            nextCycle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    task automatic testAlignment();
        checkValue("alignment", "aligned after reset", 0, aligned);
        sendCommas(commasNeeded - 1);
        checkValue("alignment", "aligned one comma short", 0, aligned);
        driveWord(evrPkg::kComma, 2'b01, 2'b00);  // last comma needed
        nextCycle();
        checkValue("alignment", "aligned one edge after last comma", 0, aligned);
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();
        checkValue("alignment", "aligned two edges after last comma", 1, aligned);
        driveWord(8'h00, 2'b00, 2'b01);  // decode error
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();
        checkValue("alignment", "aligned after decode error", 0, aligned);
        alignLink("alignment");
    endtask

    task automatic testDecode();
        evrPkg::evrCode_t       written [$];
        evrPkg::evrCode_t       c;
        evrPkg::evrCode_t       prevCode;
        logic                   k;
        logic                   good;
        logic                   prevGood;
        logic [outputCount-1:0] expTrig;
        driveWord(8'h00, 2'b00, 2'b10);  // drop alignment first
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();
        repeat (8) begin
            c = randomCode();
            written.push_back(c);
            setAction(c, 16'($urandom) & 16'h00FF, "decode");  // triggers only
        end
        driveWord(written[0], 2'b00, 2'b00);  // unaligned code
        nextCycle();
        checkValue("decode", "valid while unaligned", 0, codeValid);
        checkValue("decode", "code while unaligned", 0, code);
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();
        checkValue("decode", "trigger while unaligned", 0, trigger);
        alignLink("decode");
        prevGood = 1'b0;
        prevCode = 8'h00;
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 8)
                0: begin c = 8'h00;          k = 1'b0; end  // null code
                1: begin c = evrPkg::kComma; k = 1'b1; end  // K word
                default: begin
                    c = written[$urandom % written.size()];
                    k = 1'b0;
                end
            endcase
            good = (c != 8'h00) && !k;
            driveWord(c, {1'b0, k}, 2'b00);
            nextCycle();
            expTrig = prevGood ? expAction[prevCode][outputCount-1:0] : '0;
            checkValue("decode", "code valid", good, codeValid);
            checkValue("decode", "code", good ? c : 8'h00, code);
            checkValue("decode", "trigger", expTrig, trigger);
            prevGood = good;
            prevCode = c;
        end
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();
        expTrig = prevGood ? expAction[prevCode][outputCount-1:0] : '0;
        checkValue("decode", "last trigger", expTrig, trigger);
    endtask

    task automatic testHeartbeat();
        evrPkg::apbData_t data;
        int               width;
        driveWord(evrPkg::heartbeatCode, 2'b00, 2'b00);
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        apbRead(evrPkg::regStatus, "heartbeat", data);
        checkValue("heartbeat", "status marker bit", 1, data[1]);
        countHigh(1'b0, width);  // let it run out
        driveWord(evrPkg::heartbeatCode, 2'b00, 2'b00);
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        countHigh(1'b0, width);
        checkValue("heartbeat", "marker width", hbStretchCycles, width);
        driveWord(evrPkg::heartbeatCode, 2'b00, 2'b00);
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        repeat (hbStretchCycles / 2 - 1) nextCycle();
        checkValue("heartbeat", "marker before retrigger", 1, hbMarker);
        driveWord(evrPkg::heartbeatCode, 2'b00, 2'b00);  // restart midway
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        countHigh(1'b0, width);
        checkValue("heartbeat", "width after retrigger", hbStretchCycles, width);
    endtask

    task automatic testPps();
        int width;
        setAction(8'h5A, 16'(1) << (outputCount + 1), "pps");
        driveWord(8'h5A, 2'b00, 2'b00);
        nextCycle();
        driveWord(8'h00, 2'b00, 2'b00);
        nextCycle();  // flag is out now, marker one edge later
        checkValue("pps", "marker with flag", 0, ppsMarker);
        nextCycle();
        countHigh(1'b1, width);
        checkValue("pps", "marker width", ppsStretchCycles, width);
    endtask

    task automatic sendFlagged(input evrPkg::evrCode_t codes [5], input int n);
        for (int i = 0; i < n; i++) begin
            driveWord(codes[i], 2'b00, 2'b00);
            nextCycle();
        end
        driveWord(8'h00, 2'b00, 2'b00);
        repeat (3) nextCycle();  // drain the action and FIFO stages
    endtask

    task automatic testMonitor();
        evrPkg::evrCode_t monCodes [5];
        evrPkg::apbData_t data;
        logic             err;
        for (int i = 0; i < 5; i++) begin
            monCodes[i] = randomCode();
            setAction(monCodes[i], 16'(1) << outputCount, "monitor");
        end
        sendFlagged(monCodes, 3);
        for (int i = 0; i < 3; i++) begin
            apbRead(evrPkg::regMonitor, "monitor", data);
            checkValue("monitor", "fifo entry", {1'b1, 23'h0, monCodes[i]}, data);
        end
        apbRead(evrPkg::regStatus, "monitor", data);
        checkValue("monitor", "empty and overflow after drain", 2'b01, data[3:2]);
        apbRead(evrPkg::regMonitor, "monitor", data);
        checkValue("monitor", "read of empty fifo", 0, data);
        sendFlagged(monCodes, 5);  // one more than the depth
        apbRead(evrPkg::regStatus, "monitor", data);
        checkValue("monitor", "empty and overflow when full", 2'b10, data[3:2]);
        for (int i = 0; i < monitorDepth; i++) begin
            apbRead(evrPkg::regMonitor, "monitor", data);
            checkValue("monitor", "entry after overflow", {1'b1, 23'h0, monCodes[i]}, data);
        end
        apbRead(evrPkg::regStatus, "monitor", data);
        checkValue("monitor", "empty and overflow after reads", 2'b11, data[3:2]);
        sendFlagged(monCodes, 2);
        apbWrite(evrPkg::regControl, 32'h2, "monitor");  // clear
        apbRead(evrPkg::regStatus, "monitor", data);
        checkValue("monitor", "empty and overflow after clear", 2'b01, data[3:2]);
        // wrong direction and unmapped accesses
        apbAccess(1'b1, evrPkg::regStatus, 32'h0, data, err);
        checkValue("monitor", "pslverr on status write", 1, err);
        apbAccess(1'b0, evrPkg::regControl, 32'h0, data, err);
        checkValue("monitor", "pslverr on control read", 1, err);
        apbAccess(1'b0, 12'h100, 32'h0, data, err);
        checkValue("monitor", "pslverr on unmapped read", 1, err);
    endtask

    task automatic testSlide();
        checkValue("slide", "bitSlide idle", 0, bitSlide);
        apbWrite(evrPkg::regControl, 32'h1, "slide");
        checkValue("slide", "bitSlide after access", 1, bitSlide);
        nextCycle();
        checkValue("slide", "bitSlide second cycle", 0, bitSlide);
        nextCycle();
        checkValue("slide", "aligned after slide", 0, aligned);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h29979e19));
        rxWord     = '0;
        apbReq     = '0;
        errorCount = 0;
        for (int i = 0; i < 256; i++) begin
            expAction[i] = '0;  // table is cleared by reset
        end
        wait (rstN === 1'b1);
        nextCycle();
        testAlignment();
        testDecode();
        testHeartbeat();
        testPps();
        testMonitor();
        testSlide();
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("tests did not complete within %0d cycles", watchdogCycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: test/evrClkGen.sv
// clock and reset source for the event receiver testbench
`timescale 1ns/1ps

module evrClkGen #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 16
) (
    output logic evrClk,
    output logic rstN_o
);

    initial begin
        evrClk = 1'b0;
        forever #(periodNs / 2) evrClk = ~evrClk;
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rstN_o = 1'b0;
        repeat (resetCycles) @(posedge evrClk);
        #5 rstN_o = 1'b1;  // released off the edge, same as the stimulus
    end

endmodule

// File: src/evrTop.sv
// event receiver fabric top, alignment, decode, actions, markers and monitor FIFO on evrClk
`timescale 1ns/1ps

module evrTop #(
    parameter int evrClockRate     = 125000000,
    parameter int outputCount      = 8,
    parameter int commasNeeded     = 60,
    parameter int hbStretchCycles  = evrClockRate / 3 - 2,        // about a third of a second
    parameter int ppsStretchCycles = evrClockRate / 2000000 - 2,  // about half a microsecond
    parameter int monitorDepth     = 16
) (
    input  logic                   evrClk,
    input  logic                   rstN_i,
    input  evrPkg::rxWord_t        rxWord_i,
    input  evrPkg::apbReq_t        apb_i,
    output evrPkg::apbRsp_t        apb_o,
    output logic                   aligned_o,
    output logic                   bitSlide_o,
    output evrPkg::evrCode_t       evrCode_o,
    output logic                   evrCodeValid_o,
    output logic [outputCount-1:0] evrTrigger_o,
    output logic                   evrHbMarker_o,
    output logic                   evrPpsMarker_o
);

    evrPkg::actionWrite_t actionWrite;
    evrPkg::evrCode_t     monitorHead;
    logic                 slideReq;
    logic                 monitorPop;
    logic                 monitorClear;
    logic                 monitorFlag;
    logic                 monitorEmpty;
    logic                 monitorOverflow;
    logic                 ppsFlag;
    logic                 hbTrigger;

    ////////////////////////////////////////////////////////////////////////////
    // receive path
    evrCommaAlign #(.commasNeeded(commasNeeded)) commaAlign (
        .evrClk     (evrClk),
        .rstN_i     (rstN_i),
        .rxWord_i   (rxWord_i),
        .slideReq_i (slideReq),
        .aligned_o  (aligned_o),
        .bitSlide_o (bitSlide_o)
    );

    evrEventDecode #(.outputCount(outputCount)) eventDecode (
        .evrClk         (evrClk),
        .rstN_i         (rstN_i),
        .rxWord_i       (rxWord_i),
        .aligned_i      (aligned_o),
        .actionWrite_i  (actionWrite),
        .evrCode_o      (evrCode_o),
        .evrCodeValid_o (evrCodeValid_o),
        .evrTrigger_o   (evrTrigger_o),
        .monitorFlag_o  (monitorFlag),
        .ppsFlag_o      (ppsFlag)
    );

    ////////////////////////////////////////////////////////////////////////////
    // markers, heartbeat taken straight off the wire even before alignment
    assign hbTrigger = (rxWord_i.data[7:0] == evrPkg::heartbeatCode) && !rxWord_i.isK[0];

    evrMarkerStretch #(.stretchCycles(hbStretchCycles)) hbStretch (
        .evrClk    (evrClk),
        .rstN_i    (rstN_i),
        .trigger_i (hbTrigger),
        .marker_o  (evrHbMarker_o)
    );

    evrMarkerStretch #(.stretchCycles(ppsStretchCycles)) ppsStretch (
        .evrClk    (evrClk),
        .rstN_i    (rstN_i),
        .trigger_i (ppsFlag),
        .marker_o  (evrPpsMarker_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // monitor FIFO and host registers
    evrEventMonitor #(.monitorDepth(monitorDepth)) eventMonitor (
        .evrClk     (evrClk),
        .rstN_i     (rstN_i),
        .wrEn_i     (monitorFlag),
        .code_i     (evrCode_o),
        .pop_i      (monitorPop),
        .clear_i    (monitorClear),
        .head_o     (monitorHead),
        .empty_o    (monitorEmpty),
        .overflow_o (monitorOverflow)
    );

    evrApbRegs apbRegs (
        .evrClk            (evrClk),
        .rstN_i            (rstN_i),
        .apb_i             (apb_i),
        .aligned_i         (aligned_o),
        .hbMarker_i        (evrHbMarker_o),
        .monitorHead_i     (monitorHead),
        .monitorEmpty_i    (monitorEmpty),
        .monitorOverflow_i (monitorOverflow),
        .apb_o             (apb_o),
        .actionWrite_o     (actionWrite),
        .slideReq_o        (slideReq),
        .monitorPop_o      (monitorPop),
        .monitorClear_o    (monitorClear)
    );

endmodule

// File: src/evrApbRegs.sv
// APB register slave for status, control, monitor readout and action table writes
`timescale 1ns/1ps

module evrApbRegs (
    input  logic                 evrClk,
    input  logic                 rstN_i,
    input  evrPkg::apbReq_t      apb_i,
    input  logic                 aligned_i,
    input  logic                 hbMarker_i,
    input  evrPkg::evrCode_t     monitorHead_i,
    input  logic                 monitorEmpty_i,
    input  logic                 monitorOverflow_i,
    output evrPkg::apbRsp_t      apb_o,
    output evrPkg::actionWrite_t actionWrite_o,
    output logic                 slideReq_o,
    output logic                 monitorPop_o,
    output logic                 monitorClear_o
);

    logic               access;   // second phase, completes this cycle
    logic               wrAccess;
    logic               rdAccess;
    logic               isStatus;
    logic               isControl;
    logic               isMonitor;
    logic               isAction;
    logic               slvErr;
    evrPkg::apbData_t   rdData;

    assign access   = apb_i.psel && apb_i.penable;
    assign wrAccess = access && apb_i.pwrite;
    assign rdAccess = access && !apb_i.pwrite;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    assign isStatus  = (apb_i.paddr == evrPkg::regStatus);
    assign isControl = (apb_i.paddr == evrPkg::regControl);
    assign isMonitor = (apb_i.paddr == evrPkg::regMonitor);
    assign isAction  = (apb_i.paddr[11:10] == evrPkg::regActionBase[11:10])
                    && (apb_i.paddr[1:0] == 2'b00);  // word aligned entries only

    ////////////////////////////////////////////////////////////////////////////
    // write side, all single cycle strobes
    assign actionWrite_o = '{
        en:   wrAccess && isAction,
        code: apb_i.paddr[9:2],
        bits: apb_i.pwdata[evrPkg::actionMaxWidth-1:0]
    };

    assign slideReq_o     = wrAccess && isControl && apb_i.pwdata[0];
    assign monitorClear_o = wrAccess && isControl && apb_i.pwdata[1];

    // reading the monitor register consumes the head
    assign monitorPop_o = rdAccess && isMonitor && !monitorEmpty_i;

    ////////////////////////////////////////////////////////////////////////////
    // read side
    always_comb begin
        rdData = '0;
        if (isStatus) begin
            rdData[0] = aligned_i;
            rdData[1] = hbMarker_i;
            rdData[2] = monitorEmpty_i;
            rdData[3] = monitorOverflow_i;
        end else if (isMonitor && !monitorEmpty_i) begin
            rdData[31]  = 1'b1;           // entry valid
            rdData[7:0] = monitorHead_i;
        end
    end

    // unmapped, or the wrong direction for the register
    assign slvErr = !(isStatus || isControl || isMonitor || isAction)
                 || (apb_i.pwrite && (isStatus || isMonitor))
                 || (!apb_i.pwrite && (isControl || isAction));

    assign apb_o = '{
        prdata:  rdData,
        pready:  1'b1,               // zero wait states
        pslverr: access && slvErr
    };

    ////////////////////////////////////////////////////////////////////////////
    assertPenableWithPsel : assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        apb_i.penable |-> apb_i.psel
    );

    // each control write gives one slide request, never two back to back
    assertSlideSingle : assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        slideReq_o |=> !slideReq_o
    );

endmodule

// File: src/evrEventMonitor.sv
// event monitor FIFO, holds codes of flagged events for the host with sticky overflow
`timescale 1ns/1ps

module evrEventMonitor #(
    parameter int monitorDepth = 16   // power of two
) (
    input  logic             evrClk,
    input  logic             rstN_i,
    input  logic             wrEn_i,     // monitor flag from the action stage
    input  evrPkg::evrCode_t code_i,     // code one stage ahead of wrEn_i
    input  logic             pop_i,
    input  logic             clear_i,
    output evrPkg::evrCode_t head_o,
    output logic             empty_o,
    output logic             overflow_o
);

    localparam int addrWidth = $clog2(monitorDepth);
    localparam int ptrWidth  = addrWidth + 1;  // wrap bit tells full from empty

    evrPkg::evrCode_t      fifoMem [monitorDepth];
    evrPkg::evrCode_t      codeD;    // code lined up with its flag
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic                  full;
    logic                  doWrite;

    assign empty_o = (wrPtr == rdPtr);
    assign full    = (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0])
                  && (wrPtr[addrWidth] != rdPtr[addrWidth]);
    assign doWrite = wrEn_i && !full;
    assign head_o  = fifoMem[rdPtr[addrWidth-1:0]];

    // code is one cycle ahead of the flag, hold it back a stage
    always_ff @(posedge evrClk) begin
        codeD <= code_i;
    end

    always_ff @(posedge evrClk) begin
        if (doWrite) begin
            fifoMem[wrPtr[addrWidth-1:0]] <= codeD;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers and overflow
    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            overflow_o <= 1'b0;
        end else if (clear_i) begin
            wrPtr      <= '0;  // clear wins over a write in the same cycle
            rdPtr      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (wrEn_i && full) begin
                overflow_o <= 1'b1;  // event lost, stays set until clear
            end
            if (pop_i && !empty_o) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // register block must only pop when it has seen an entry
    assertNoEmptyPop : assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        pop_i |-> !empty_o
    );

endmodule

// File: src/evrMarkerStretch.sv
// retriggerable pulse stretcher, turns a single cycle event into a visible marker
`timescale 1ns/1ps

module evrMarkerStretch #(
    parameter int stretchCycles = 20
) (
    input  logic evrClk,
    input  logic rstN_i,
    input  logic trigger_i,
    output logic marker_o
);

    // counter runs up from minus the length, sign bit is the marker
    localparam int stretchWidth = $clog2(stretchCycles + 1) + 1;
    localparam logic [stretchWidth-1:0] stretchLoad =
        stretchWidth'(0) - stretchWidth'(stretchCycles);

    logic [stretchWidth-1:0] stretchCount;

    assign marker_o = stretchCount[stretchWidth-1];

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            stretchCount <= '0;  // idle, marker low
        end else if (trigger_i) begin
            stretchCount <= stretchLoad;  // restart even when already running
        end else if (marker_o) begin
            stretchCount <= stretchCount + 1'b1;
        end
    end

endmodule

// File: src/evrEventDecode.sv
// event code filter and register, plus the 256 entry code to action table
`timescale 1ns/1ps

module evrEventDecode #(
    parameter int outputCount = 8
) (
    input  logic                 evrClk,
    input  logic                 rstN_i,
    input  evrPkg::rxWord_t      rxWord_i,
    input  logic                 aligned_i,
    input  evrPkg::actionWrite_t actionWrite_i,
    output evrPkg::evrCode_t     evrCode_o,
    output logic                 evrCodeValid_o,
    output logic [outputCount-1:0] evrTrigger_o,
    output logic                 monitorFlag_o,
    output logic                 ppsFlag_o
);

    // triggers in the low bits, then monitor, then pps
    localparam int actionWidth = outputCount + 2;

    logic [actionWidth-1:0] actionTable [256];
    logic [actionWidth-1:0] actions;
    logic                   goodCode;

    ////////////////////////////////////////////////////////////////////////////
    // code filter
    assign goodCode = aligned_i
                   && (rxWord_i.data[7:0] != 8'h00)
                   && !rxWord_i.isK[0];  // control characters are not events

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            evrCode_o      <= '0;
            evrCodeValid_o <= 1'b0;
        end else begin
            evrCode_o      <= goodCode ? rxWord_i.data[7:0] : 8'h00;
            evrCodeValid_o <= goodCode;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // action table, written from APB, read with the registered code
    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 256; i++) begin
                actionTable[i] <= '0;  // no event fires anything after reset
            end
        end else if (actionWrite_i.en) begin
            actionTable[actionWrite_i.code] <= actionWrite_i.bits[actionWidth-1:0];
        end
    end

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            actions <= '0;
        end else begin
            // second pipeline stage, code in flight behind it
            actions <= evrCodeValid_o ? actionTable[evrCode_o] : '0;
        end
    end

    assign evrTrigger_o  = actions[outputCount-1:0];
    assign monitorFlag_o = actions[outputCount];
    assign ppsFlag_o     = actions[outputCount+1];

    // no valid code in the previous stage means quiet outputs
    assertQuietActions : assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        !evrCodeValid_o |=> (actions == '0)
    );

endmodule

// File: src/evrCommaAlign.sv
// comma alignment detector, counts consecutive K28.5 words and drives the bit-slide pulse
`timescale 1ns/1ps

module evrCommaAlign #(
    parameter int commasNeeded = 60
) (
    input  logic            evrClk,
    input  logic            rstN_i,
    input  evrPkg::rxWord_t rxWord_i,
    input  logic            slideReq_i,   // one cycle request from the register block
    output logic            aligned_o,
    output logic            bitSlide_o    // to transceiver slide input
);

    // down counter, an extra bit on top becomes the aligned flag
    localparam int countReload = commasNeeded - 1;
    localparam int countWidth  = $clog2(countReload + 1) + 1;

    logic [countWidth-1:0] commaCount;
    logic                  alignedFlag;
    logic                  isComma;
    logic                  reload;

    assign alignedFlag = commaCount[countWidth-1];  // sign bit

    // K28.5 only counts in the low byte
    assign isComma = rxWord_i.isK[0] && (rxWord_i.data[7:0] == evrPkg::kComma);

    // decode error, K in the high byte, or a slide in progress all restart the count
    assign reload = (rxWord_i.notInTable != 2'b00) || rxWord_i.isK[1] || bitSlide_o;

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            commaCount <= countWidth'(countReload);
            aligned_o  <= 1'b0;
            bitSlide_o <= 1'b0;
        end else begin
            bitSlide_o <= slideReq_i;   // one cycle after the control write
            aligned_o  <= alignedFlag;  // registered copy for the outside
            if (reload) begin
                commaCount <= countWidth'(countReload);
            end else if (!alignedFlag && isComma) begin
                commaCount <= commaCount - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // once aligned the count is frozen until something forces a reload
    assertAlignedHold : assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        (alignedFlag && !reload) |=> $stable(commaCount)
    );

endmodule

// File: src/evrPkg.sv
// event receiver shared types, symbols and register map for the fabric side
package evrPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths with a meaning
    typedef logic [7:0]  evrCode_t;   // one event code
    typedef logic [11:0] apbAddr_t;   // byte address inside the receiver window
    typedef logic [31:0] apbData_t;

    // widest action word the table can hold, triggers + monitor + pps
    localparam int actionMaxWidth = 16;

    ////////////////////////////////////////////////////////////////////////////
    // transceiver word, two decoded bytes per evrClk
    typedef struct packed {
        logic [15:0] data;        // low byte carries the event code
        logic [1:0]  isK;         // per byte control character flag
        logic [1:0]  notInTable;  // per byte 8b/10b decode error
    } rxWord_t;

    // APB request from the host side
    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    // APB response, never stalls
    typedef struct packed {
        apbData_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    // one action table write
    typedef struct packed {
        logic                      en;
        evrCode_t                  code;   // entry index
        logic [actionMaxWidth-1:0] bits;   // new action word, low bits used
    } actionWrite_t;

    ////////////////////////////////////////////////////////////////////////////
    // special characters and codes
    localparam evrCode_t kComma        = 8'hBC;  // K28.5
    localparam evrCode_t heartbeatCode = 8'd122;

    ////////////////////////////////////////////////////////////////////////////
    // register offsets
    localparam apbAddr_t regStatus     = 12'h000;  // read only
    localparam apbAddr_t regControl    = 12'h004;  // write only
    localparam apbAddr_t regMonitor    = 12'h008;  // read pops the FIFO head
    localparam apbAddr_t regActionBase = 12'h400;  // 256 word entries, write only

endpackage
